/* files.f */
+incdir+include
verilog/ptp_bus_pkg.sv
verilog/ptp_sync_pkg.sv
verilog/ptp_csr.sv
verilog/ptp_exchange.sv
verilog/ptp_sync_top.sv
verif/ptp_sync_tb.sv

/* Makefile */
# Verilator flow for the piezo time-sync core

TB = ptp_sync_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f files.f \
		--top-module ptp_sync_top
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f files.f \
		--top-module $(TB)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
		--top-module $(TB) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* verif/ptp_sync_tb.sv */
module ptp_sync_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CYCLE_LIMIT = 3000; // whole sequence runs a few hundred cycles
	localparam int BURST_LEN = 6; // counter values 0 to 5 drive the line

	logic        clock;
	logic        reset;
	logic [15:0] address;
	logic        write;
	logic [31:0] writedata;
	logic        read;
	logic        piezo_in;
	logic [31:0] readdata;
	logic        waitrequest;
	logic        piezo_out;

	int          cycle_count;
	int          err_value;
	int          err_proto;
	int          seed;
	int          rise_count;
	int          burst_count;
	int          run_len;
	int          last_rise_edge;
	int          base;
	logic        prev_out;
	logic [31:0] expected;
	logic [31:0] scratch;

	ptp_sync_top UUT (
		.clock       (clock),
		.reset       (reset),
		.address     (address),
		.write       (write),
		.writedata   (writedata),
		.read        (read),
		.piezo_in    (piezo_in),
		.readdata    (readdata),
		.waitrequest (waitrequest),
		.piezo_out   (piezo_out)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1; // edges seen so far
	end

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("run stopped at the cycle limit of %0d before the sequence ended", CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	// ============================================================
	// piezo line monitor and bus protocol assertions
	// ============================================================
	always @(negedge clock) begin
		if (!reset) begin
			if (piezo_out && !prev_out) begin
				rise_count++;
				last_rise_edge = cycle_count; // edge where the counter was 0
				run_len = 0;
			end
			if (piezo_out) begin
				run_len++;
			end
			if (!piezo_out && prev_out) begin
				burst_count++;
				assert (run_len == BURST_LEN) else begin
					err_value++;
					$display("Mismatch piezo_out burst length: expected %h, got %h",
						BURST_LEN, run_len);
				end
			end
		end
		prev_out = piezo_out;
	end

	idle_wait: assert property (@(posedge clock) disable iff (reset) !read |-> !waitrequest)
		else begin
			err_proto++;
			$display("waitrequest was high while read was low");
		end

	first_wait: assert property (@(posedge clock) disable iff (reset) $rose(read) |-> waitrequest)
		else begin
			err_proto++;
			$display("waitrequest was low in the first cycle of a read");
		end

	one_wait: assert property (@(posedge clock) disable iff (reset)
		read && waitrequest |=> !waitrequest)
		else begin
			err_proto++;
			$display("waitrequest stayed high for more than one read cycle");
		end

	// ============================================================
	// bus and stimulus tasks
	// ============================================================
	task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
		@(posedge clock);
		#2;
		write = 1'b1;
		address = addr;
		writedata = data;
		@(negedge clock);
		while (waitrequest) begin
			@(negedge clock);
		end
		@(posedge clock); // accepted here
		#2;
		write = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
		int waits;
		waits = 0;
		data = '0;
		@(posedge clock);
		#2;
		read = 1'b1;
		address = addr;
		@(negedge clock);
		while (waitrequest && waits < 8) begin
			waits++;
			@(negedge clock);
		end
		if (waitrequest) begin
			err_proto++;
			$display("read at address %h never completed", addr);
		end else begin
			data = readdata;
		end
		assert (waits == 1) else begin
			err_proto++;
			$display("read at address %h took %0d wait cycles instead of one", addr, waits);
		end
		@(posedge clock);
		#2;
		read = 1'b0;
	endtask

	task automatic expect_read(input logic [15:0] addr, input logic [31:0] exp,
		input string name);
		logic [31:0] data;
		bus_read(addr, data);
		assert (data === exp) else begin
			err_value++;
			$display("Mismatch %s at address %h: expected %h, got %h", name, addr, exp, data);
		end
	endtask

	// one cycle pulse that returns the travel time the engine should capture
	task automatic send_pulse(output logic [31:0] travel);
		@(posedge clock);
		#2;
		piezo_in = 1'b1;
		travel = cycle_count + 1 - last_rise_edge; // sampled on the next edge
		@(posedge clock);
		#2;
		piezo_in = 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) @(posedge clock);
	endtask

	task automatic wait_bursts(input int target);
		int guard;
		guard = 0;
		while (burst_count < target && guard < 40) begin
			@(posedge clock);
			guard++;
		end
		assert (burst_count >= target) else begin
			err_proto++;
			$display("piezo_out burst number %0d did not appear within 40 cycles", target);
		end
	endtask

	// late peer pulses must not wake a finished engine
	task automatic check_quiet(input string who);
		int rises;
		rises = rise_count;
		send_pulse(scratch);
		idle(2 + ($unsigned($random(seed)) % 6));
		send_pulse(scratch);
		idle(10);
		assert (rise_count == rises && piezo_out === 1'b0) else begin
			err_proto++;
			$display("%s engine drove piezo_out after it had finished", who);
		end
	endtask

	// ============================================================
	// test sequence
	// ============================================================
	initial begin
		seed = 6;
		err_value = 0;
		err_proto = 0;
		rise_count = 0;
		burst_count = 0;
		run_len = 0;
		last_rise_edge = 0;
		prev_out = 1'b0;
		reset = 1'b1;
		address = '0;
		write = 1'b0;
		writedata = '0;
		read = 1'b0;
		piezo_in = 1'b0;
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;

		assert (piezo_out === 1'b0) else begin
			err_value++;
			$display("Mismatch piezo_out after reset: expected 0, got %h", piezo_out);
		end
		expect_read(16'h0000, 32'h1, "master travel_time");
		expect_read(16'h0100, 32'h1, "slave travel_time");
		expect_read(16'h0200, 32'hDEADBEEF, "readdata unmapped");

		// master opens with one burst and then waits for the peer
		bus_write(16'h0003, 32'h1);
		wait_bursts(1);
		idle(10 + ($unsigned($random(seed)) % 10));
		assert (rise_count == 1) else begin
			err_proto++;
			$display("master sent a second burst before any piezo_in pulse");
		end
		send_pulse(expected);
		wait_bursts(2); // answer burst before the stop
		idle(12);
		expect_read(16'h0000, expected, "master travel_time");
		check_quiet("master");

		// slave listens first and answers each pulse
		base = burst_count;
		bus_write(16'h0003, 32'h3);
		idle(20);
		assert (burst_count == base && piezo_out === 1'b0) else begin
			err_proto++;
			$display("slave drove piezo_out before the first piezo_in pulse");
		end
		send_pulse(scratch);
		wait_bursts(base + 1);
		idle(2 + ($unsigned($random(seed)) % 8));
		send_pulse(expected);
		wait_bursts(base + 2);
		idle(12);
		expect_read(16'h0100, expected, "slave travel_time");
		expect_read(16'h0000, 32'h1, "master travel_time"); // cleared by the restart
		check_quiet("slave");

		$display("errors: %0d value mismatches, %0d protocol failures", err_value, err_proto);
		if (err_value + err_proto == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* verilog/ptp_sync_top.sv */
`include "ptp_defs.svh"

module ptp_sync_top (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [`PTP_ADDR_W-1:0]  address,
	input  logic                    write,
	input  logic [`PTP_DATA_W-1:0]  writedata,
	input  logic                    read,
	input  logic                    piezo_in,
	output logic [`PTP_DATA_W-1:0]  readdata,
	output logic                    waitrequest,
	output logic                    piezo_out
);
	import ptp_sync_pkg::*;

	logic                   restart;
	logic                   master_enable;
	logic                   slave_enable;
	logic                   master_pulse;
	logic                   slave_pulse;
	logic [`PTP_DATA_W-1:0] master_time;
	logic [`PTP_DATA_W-1:0] slave_time;
	logic                   master_finished;
	logic                   slave_finished;

	assign piezo_out = master_pulse | slave_pulse; // shared piezo line

	ptp_csr csr (
		.clock           (clock),
		.reset           (reset),
		.address         (address),
		.write           (write),
		.writedata       (writedata),
		.read            (read),
		.master_time     (master_time),
		.slave_time      (slave_time),
		.master_finished (master_finished),
		.slave_finished  (slave_finished),
		.readdata        (readdata),
		.waitrequest     (waitrequest),
		.restart         (restart),
		.master_enable   (master_enable),
		.slave_enable    (slave_enable)
	);

	ptp_exchange #(.ROLE(ROLE_MASTER)) master_engine (
		.clock       (clock),
		.reset       (reset),
		.restart     (restart),
		.enable      (master_enable),
		.pulse_in    (piezo_in),
		.pulse_out   (master_pulse),
		.travel_time (master_time),
		.finished    (master_finished)
	);

	ptp_exchange #(.ROLE(ROLE_SLAVE)) slave_engine (
		.clock       (clock),
		.reset       (reset),
		.restart     (restart),
		.enable      (slave_enable),
		.pulse_in    (piezo_in),
		.pulse_out   (slave_pulse),
		.travel_time (slave_time),
		.finished    (slave_finished)
	);

endmodule

/* verilog/ptp_exchange.sv */
`include "ptp_defs.svh"

module ptp_exchange #(
	parameter ptp_sync_pkg::ptp_role_t ROLE = ptp_sync_pkg::ROLE_MASTER
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    restart,
	input  logic                    enable,
	input  logic                    pulse_in,
	output logic                    pulse_out,
	output logic [`PTP_DATA_W-1:0]  travel_time,
	output logic                    finished
);
	import ptp_sync_pkg::*;

	// master opens with a burst, slave waits for the peer
	localparam logic START_LISTEN = (ROLE == ROLE_SLAVE);
	localparam logic [`PTP_DATA_W-1:0] START_CONV = (ROLE == ROLE_MASTER) ? 1 : 0;

	logic [`PTP_DATA_W-1:0] cycle_cnt;
	logic [`PTP_DATA_W-1:0] conv_cnt; // exchanges seen so far
	logic                   listening; // low while talking
	logic                   talked; // burst sent since the last listen

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			cycle_cnt   <= '0;
			conv_cnt    <= START_CONV;
			listening   <= START_LISTEN;
			talked      <= 1'b0;
			pulse_out   <= 1'b0;
			travel_time <= 1;
			finished    <= 1'b0;
		end else if (restart) begin
			cycle_cnt   <= '0;
			conv_cnt    <= START_CONV;
			listening   <= START_LISTEN;
			talked      <= 1'b0;
			pulse_out   <= 1'b0;
			travel_time <= 1;
			finished    <= 1'b0;
		end else if (enable) begin
			pulse_out <= 1'b0;
			cycle_cnt <= cycle_cnt + 1'b1;

			if (!listening) begin
				// talk phase
				talked <= 1'b1;
				if (cycle_cnt <= `PTP_TALK_LAST) begin
					pulse_out <= 1'b1;
				end
				if (cycle_cnt >= `PTP_TALK_END) begin
					listening <= 1'b1;
				end
			end else begin
				// listen phase, peer pulse closes the round trip
				if (pulse_in) begin
					conv_cnt <= conv_cnt + 1'b1;
					if (talked && !finished) begin
						travel_time <= cycle_cnt;
					end
					cycle_cnt <= '0;
					talked    <= 1'b0;
					listening <= 1'b0; // answer with a burst
				end
				if (conv_cnt >= `PTP_CONV_CYCLES) begin
					finished <= 1'b1; // held until restart
				end
			end
		end
	end

endmodule

/* verilog/ptp_csr.sv */
`include "ptp_defs.svh"

module ptp_csr (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [`PTP_ADDR_W-1:0]   address,
	input  logic                     write,
	input  ptp_bus_pkg::csr_wdata_u  writedata,
	input  logic                     read,
	input  logic [`PTP_DATA_W-1:0]   master_time,
	input  logic [`PTP_DATA_W-1:0]   slave_time,
	input  logic                     master_finished,
	input  logic                     slave_finished,
	output logic [`PTP_DATA_W-1:0]   readdata,
	output logic                     waitrequest,
	output logic                     restart,
	output logic                     master_enable,
	output logic                     slave_enable
);
	import ptp_bus_pkg::*;
	import ptp_sync_pkg::*;

	ptp_role_t role;
	ptp_role_t start_role;
	logic      sync_en;
	logic      start_go; // start command waiting for its first edge
	logic      start_delay;
	logic      finished_q;
	logic      wait_flag;
	logic      wr_accept;
	csr_addr_t wr_addr;
	csr_rsel_t rd_sel;

	assign wr_addr = csr_addr_t'(address[7:0]);
	assign rd_sel = csr_rsel_t'(address[`PTP_ADDR_W-1:8]);

	// upper byte has to be zero for a write to land
	assign wr_accept = write && !waitrequest && (address[`PTP_ADDR_W-1:8] == 8'h00);

	assign master_enable = sync_en && (role == ROLE_MASTER);
	assign slave_enable = sync_en && (role == ROLE_SLAVE);

	// ============================================================
	// read side with a single wait state
	// ============================================================
	assign waitrequest = read && wait_flag;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wait_flag <= 1'b1;
		end else begin
			wait_flag <= 1'b1; // re-arms after the data cycle
			if (read && wait_flag) begin
				wait_flag <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (read && wait_flag) begin
			case (rd_sel)
				RSEL_MASTER_TIME: readdata <= master_time;
				RSEL_SLAVE_TIME:  readdata <= slave_time;
				default:          readdata <= `PTP_READ_MISS;
			endcase
		end
	end

	// ============================================================
	// control registers, start sequence and auto-stop
	// ============================================================
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			role        <= ROLE_MASTER;
			start_role  <= ROLE_MASTER;
			sync_en     <= 1'b0;
			restart     <= 1'b0;
			start_go    <= 1'b0;
			start_delay <= 1'b0;
			finished_q  <= 1'b0;
		end else begin
			restart     <= 1'b0;
			start_delay <= 1'b0;
			// old finished flags are dropped while the engines restart
			finished_q <= (master_finished || slave_finished) && !restart;
			if (finished_q) begin
				sync_en <= 1'b0;
			end

			// first edge of a start
			if (start_go) begin
				start_go    <= 1'b0;
				role        <= start_role;
				sync_en     <= 1'b0;
				restart     <= 1'b1;
				start_delay <= 1'b1;
			end
			if (start_delay) begin
				sync_en <= 1'b1; // engines run from here on
			end

			if (wr_accept) begin
				case (wr_addr)
					CSR_ROLE:    role <= ptp_role_t'(writedata.word != '0);
					CSR_SYNC_EN: sync_en <= (writedata.word != '0);
					CSR_RESTART: restart <= (writedata.word != '0);
					CSR_START: begin
						start_go   <= writedata.start.go;
						start_role <= ptp_role_t'(writedata.start.role);
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* verilog/ptp_sync_pkg.sv */
package ptp_sync_pkg;

	// which side of the exchange an engine plays
	typedef enum logic {
		ROLE_MASTER = 1'b0,
		ROLE_SLAVE  = 1'b1
	} ptp_role_t;

endpackage

/* verilog/ptp_bus_pkg.sv */
`include "ptp_defs.svh"

package ptp_bus_pkg;

	// write offsets in the low address byte
	typedef enum logic [7:0] {
		CSR_ROLE    = 8'h00,
		CSR_SYNC_EN = 8'h01,
		CSR_RESTART = 8'h02,
		CSR_START   = 8'h03
	} csr_addr_t;

	// read select in the upper address byte
	typedef enum logic [7:0] {
		RSEL_MASTER_TIME = 8'h00,
		RSEL_SLAVE_TIME  = 8'h01
	} csr_rsel_t;

	typedef struct packed {
		logic [`PTP_DATA_W-3:0] reserved;
		logic                   role; // 1 selects slave
		logic                   go;
	} csr_start_t;

	// flag registers look at the whole word, the start command at its bits
	typedef union packed {
		logic [`PTP_DATA_W-1:0] word;
		csr_start_t             start;
	} csr_wdata_u;

endpackage

/* include/ptp_defs.svh */
`ifndef PTP_DEFS_SVH
`define PTP_DEFS_SVH

// ============================================================
// bus geometry
// ============================================================
`define PTP_DATA_W 32 // also the cycle counter width
`define PTP_ADDR_W 16

// ============================================================
// exchange timing in enabled clock cycles
// ============================================================
`define PTP_TALK_LAST 5 // burst driven up to this count
`define PTP_TALK_END 7 // switch over to listening here
`define PTP_CONV_CYCLES 2 // exchanges before the engine stops

// returned for any unmapped read select
`define PTP_READ_MISS 32'hDEADBEEF

`endif
